// ==== common/soc_pkg.sv ====
// Shared bus types, address map and register offsets for the SoC
// Slaves are chosen by address bits 31:28; unmapped regions decode to NONE
// Register offsets are compared against address bits 3:0 only
`default_nettype none

package soc_pkg;

  ////////////////////////////////////////////////////////////
  // Bus payloads
  ////////////////////////////////////////////////////////////

  // Master to slave, held stable while cyc is high
  typedef struct packed {
    logic        cyc;
    logic        we;
    logic [3:0]  strb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // Slave to master, rdata qualified by ack
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    MEM  = 2'd0,
    DMA  = 2'd1,
    KEY  = 2'd2,
    NONE = 2'd3
  } slave_sel_e;

  // DMA register block
  localparam logic [3:0] DMA_SRC_OFS  = 4'h0;
  localparam logic [3:0] DMA_DST_OFS  = 4'h4;
  localparam logic [3:0] DMA_LEN_OFS  = 4'h8;
  localparam logic [3:0] DMA_CTRL_OFS = 4'hC;

  // Keyboard port
  localparam logic [3:0] KEY_DATA_OFS = 4'h0;
  localparam logic [3:0] KEY_STAT_OFS = 4'h4;

  // Region decode from the top nibble
  function automatic slave_sel_e decode_sel(input logic [31:0] addr);
    case (addr[31:28])
      4'h0:    return MEM;
      4'h1:    return DMA;
      4'h2:    return KEY;
      default: return NONE;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== rtl/bus_interconnect.sv ====
// Two-master, three-slave shared bus with a registered grant
// Round-robin on contention, CPU first after reset
// Grant is held until the owner sees ack; masters must drop cyc after it
// Unmapped addresses are acked here with zero data
`timescale 1ns/1ps
`default_nettype none

module bus_interconnect (
  input  logic              clk,
  input  logic              reset_i,
  input  soc_pkg::bus_req_t cpu_req_i,
  input  soc_pkg::bus_req_t dma_req_i,
  input  soc_pkg::bus_rsp_t mem_rsp_i,
  input  soc_pkg::bus_rsp_t dreg_rsp_i,
  input  soc_pkg::bus_rsp_t key_rsp_i,
  output soc_pkg::bus_rsp_t cpu_rsp_o,
  output soc_pkg::bus_rsp_t dma_rsp_o,
  output soc_pkg::bus_req_t mem_req_o,
  output soc_pkg::bus_req_t dreg_req_o,
  output soc_pkg::bus_req_t key_req_o
);
  import soc_pkg::*;

  logic       gnt_cpu_q;
  logic       gnt_dma_q;
  // Set when the DMA wins the next tie
  logic       rr_dma_q;
  logic       none_ack_q;
  logic       bus_idle;
  bus_req_t   own_req;
  bus_rsp_t   own_rsp;
  slave_sel_e sel;

  assign bus_idle = ~gnt_cpu_q & ~gnt_dma_q;

  ////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////

  // Owner's request, all zero with no grant
  always_comb begin
    if (gnt_cpu_q) begin
      own_req = cpu_req_i;
    end else if (gnt_dma_q) begin
      own_req = dma_req_i;
    end else begin
      own_req = '0;
    end
  end

  assign sel = decode_sel(own_req.addr);

  // Only the addressed slave sees the request
  always_comb begin
    mem_req_o  = '0;
    dreg_req_o = '0;
    key_req_o  = '0;
    case (sel)
      MEM:     mem_req_o  = own_req;
      DMA:     dreg_req_o = own_req;
      KEY:     key_req_o  = own_req;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (sel)
      MEM:     own_rsp = mem_rsp_i;
      DMA:     own_rsp = dreg_rsp_i;
      KEY:     own_rsp = key_rsp_i;
      default: own_rsp = '{ack: none_ack_q, rdata: 32'h0};
    endcase
  end

  // Non-owner sees ack low
  assign cpu_rsp_o = gnt_cpu_q ? own_rsp : '0;
  assign dma_rsp_o = gnt_dma_q ? own_rsp : '0;

  ////////////////////////////////////////////////////////////
  // Grant and default slave
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      gnt_cpu_q  <= 1'b0;
      gnt_dma_q  <= 1'b0;
      rr_dma_q   <= 1'b0;
      none_ack_q <= 1'b0;
    end else begin
      // Default slave, one ack per access
      none_ack_q <= own_req.cyc & (sel == NONE) & ~none_ack_q;
      if (bus_idle) begin
        // CPU wins unless both request and it is the DMA's turn
        if (cpu_req_i.cyc && (!dma_req_i.cyc || !rr_dma_q)) begin
          gnt_cpu_q <= 1'b1;
          rr_dma_q  <= 1'b1;
        end else if (dma_req_i.cyc) begin
          gnt_dma_q <= 1'b1;
          rr_dma_q  <= 1'b0;
        end
      end else if (own_rsp.ack) begin
        // Release with the ack, bus idle next cycle
        gnt_cpu_q <= 1'b0;
        gnt_dma_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/main_mem.sv ====
// Word memory as a bus slave, one inferred array, contents not reset
// Index is address bits above 2, modulo MEM_WORDS
// Writes take effect in the ack cycle under the byte strobes
`timescale 1ns/1ps
`default_nettype none

module main_mem #(
  parameter int MEM_WORDS = 1024
) (
  input  logic              clk,
  input  logic              reset_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o
);
  import soc_pkg::*;

  localparam int AW = $clog2(MEM_WORDS);

  logic [31:0]   mem_q [MEM_WORDS];
  logic [31:0]   rdata_q;
  logic          ack_q;
  logic          access;
  logic [AW-1:0] word_idx;

  // New access only, not the one being acked
  assign access   = req_i.cyc & ~ack_q;
  assign word_idx = AW'(req_i.addr[31:2] % MEM_WORDS);

  // Ack pulse
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Array and read register
  always_ff @(posedge clk) begin
    if (access) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b]) begin
            mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  assign rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== rtl/keyboard.sv ====
// Keyboard receive port, scan codes queued in a circular FIFO
// KEY_DEPTH is a power of two, at least 2, at most 128
// A strobe while full drops the code even if a pop happens that cycle
// Writes are acked and ignored
`timescale 1ns/1ps
`default_nettype none

module keyboard #(
  parameter int KEY_DEPTH = 8
) (
  input  logic              clk,
  input  logic              reset_i,
  input  soc_pkg::bus_req_t req_i,
  input  logic              key_valid_i,
  input  logic [7:0]        key_code_i,
  output soc_pkg::bus_rsp_t rsp_o
);
  import soc_pkg::*;

  localparam int PW = $clog2(KEY_DEPTH);

  logic [7:0]  fifo_q [KEY_DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW:0] count_q;
  logic        ovf_q;
  logic        ack_q;
  logic [31:0] rdata_q;
  logic        access;
  logic        rd_data;
  logic        rd_stat;
  logic        empty;
  logic        full;
  logic        push;
  logic        pop;
  logic        drop;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign access  = req_i.cyc & ~ack_q;
  assign rd_data = access & ~req_i.we & (req_i.addr[3:0] == KEY_DATA_OFS);
  assign rd_stat = access & ~req_i.we & (req_i.addr[3:0] == KEY_STAT_OFS);

  assign empty = (count_q == '0);
  assign full  = (count_q == (PW+1)'(KEY_DEPTH));
  // Data read pops only a non-empty FIFO
  assign pop   = rd_data & ~empty;
  assign push  = key_valid_i & ~full;
  assign drop  = key_valid_i & full;

  ////////////////////////////////////////////////////////////
  // FIFO control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ovf_q    <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= access;
      // Pointers wrap naturally
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      // Status read clears, a new drop wins
      if (rd_stat) begin
        ovf_q <= 1'b0;
      end
      if (drop) begin
        ovf_q <= 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= key_code_i;
    end
  end

  // Read data, bit 8 marks a valid code
  always_ff @(posedge clk) begin
    if (rd_data) begin
      rdata_q <= empty ? '0 : {23'b0, 1'b1, fifo_q[rd_ptr_q]};
    end else if (rd_stat) begin
      rdata_q <= {23'b0, ovf_q, 8'(count_q)};
    end else begin
      rdata_q <= '0;
    end
  end

  assign rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== dma/dma_engine.sv ====
// Memory to memory DMA, one word read then one word write per step
// Register writes take the whole word; strobes are not applied
// A start clears done and irq; LEN of zero completes in the start cycle
// SRC, DST and LEN writes while busy are acked and dropped
`timescale 1ns/1ps
`default_nettype none

module dma_engine (
  input  logic              clk,
  input  logic              reset_i,
  input  soc_pkg::bus_req_t s_req_i,
  input  soc_pkg::bus_rsp_t m_rsp_i,
  input  logic              irq_clear_i,
  output soc_pkg::bus_rsp_t s_rsp_o,
  output soc_pkg::bus_req_t m_req_o,
  output logic              irq_o
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RD_REQ,
    WR_REQ,
    GAP
  } state_e;

  state_e      state_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [31:0] len_q;
  logic [31:0] cur_src_q;
  logic [31:0] cur_dst_q;
  logic [31:0] remain_q;
  logic [31:0] hold_q;
  // Next request after GAP is the write
  logic        wr_next_q;
  logic        done_q;
  logic        irq_q;
  logic        s_ack_q;
  logic [31:0] s_rdata_q;
  logic        s_acc;
  logic        s_wr;
  logic        s_rd;
  logic        busy;
  logic        start;
  logic        complete;

  ////////////////////////////////////////////////////////////
  // Register slave
  ////////////////////////////////////////////////////////////

  assign busy  = (state_q != IDLE);
  assign s_acc = s_req_i.cyc & ~s_ack_q;
  assign s_wr  = s_acc & s_req_i.we;
  assign s_rd  = s_acc & ~s_req_i.we;

  // Go bit only honoured while idle
  assign start = s_wr & ~busy & (s_req_i.addr[3:0] == DMA_CTRL_OFS) & s_req_i.wdata[0];

  // Last write acked, or empty copy
  assign complete = (start && len_q == '0) ||
                    (state_q == WR_REQ && m_rsp_i.ack && remain_q == 32'd1);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      s_ack_q <= 1'b0;
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
    end else begin
      s_ack_q <= s_acc;
      if (s_wr && !busy) begin
        case (s_req_i.addr[3:0])
          DMA_SRC_OFS: src_q <= s_req_i.wdata;
          DMA_DST_OFS: dst_q <= s_req_i.wdata;
          DMA_LEN_OFS: len_q <= s_req_i.wdata;
          default:     ;
        endcase
      end
    end
  end

  // Readback, CTRL holds busy and done
  always_ff @(posedge clk) begin
    if (s_rd) begin
      case (s_req_i.addr[3:0])
        DMA_SRC_OFS:  s_rdata_q <= src_q;
        DMA_DST_OFS:  s_rdata_q <= dst_q;
        DMA_LEN_OFS:  s_rdata_q <= len_q;
        DMA_CTRL_OFS: s_rdata_q <= {30'b0, done_q, busy};
        default:      s_rdata_q <= '0;
      endcase
    end
  end

  assign s_rsp_o = '{ack: s_ack_q, rdata: s_rdata_q};

  ////////////////////////////////////////////////////////////
  // Copy sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= IDLE;
      cur_src_q <= '0;
      cur_dst_q <= '0;
      remain_q  <= '0;
      wr_next_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start && len_q != '0) begin
            cur_src_q <= src_q;
            cur_dst_q <= dst_q;
            remain_q  <= len_q;
            wr_next_q <= 1'b0;
            state_q   <= RD_REQ;
          end
        end
        RD_REQ: begin
          if (m_rsp_i.ack) begin
            wr_next_q <= 1'b1;
            state_q   <= GAP;
          end
        end
        WR_REQ: begin
          if (m_rsp_i.ack) begin
            wr_next_q <= 1'b0;
            cur_src_q <= cur_src_q + 32'd4;
            cur_dst_q <= cur_dst_q + 32'd4;
            remain_q  <= remain_q - 32'd1;
            state_q   <= (remain_q == 32'd1) ? IDLE : GAP;
          end
        end
        // cyc low for one cycle between requests
        GAP:     state_q <= wr_next_q ? WR_REQ : RD_REQ;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Word in flight
  always_ff @(posedge clk) begin
    if (state_q == RD_REQ && m_rsp_i.ack) begin
      hold_q <= m_rsp_i.rdata;
    end
  end

  // Master request straight from state
  always_comb begin
    m_req_o.cyc   = (state_q == RD_REQ) || (state_q == WR_REQ);
    m_req_o.we    = (state_q == WR_REQ);
    m_req_o.strb  = 4'hF;
    m_req_o.addr  = (state_q == WR_REQ) ? cur_dst_q : cur_src_q;
    m_req_o.wdata = hold_q;
  end

  ////////////////////////////////////////////////////////////
  // Done flag and interrupt
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      done_q <= 1'b0;
      irq_q  <= 1'b0;
    end else begin
      if (start || irq_clear_i) begin
        done_q <= 1'b0;
        irq_q  <= 1'b0;
      end
      // Completion beats a clear in the same cycle
      if (complete) begin
        done_q <= 1'b1;
        irq_q  <= 1'b1;
      end
    end
  end

  assign irq_o = irq_q;

endmodule

`default_nettype wire

// ==== rtl/soc_system.sv ====
// SoC top, CPU master port brought out as top-level ports
// Map: 0x0xxx_xxxx memory, 0x1 DMA registers, 0x2 keyboard, others unmapped
`timescale 1ns/1ps
`default_nettype none

module soc_system #(
  parameter int MEM_WORDS = 1024,
  parameter int KEY_DEPTH = 8
) (
  input  logic              clk,
  input  logic              reset_i,
  input  soc_pkg::bus_req_t cpu_req_i,
  input  logic              key_valid_i,
  input  logic [7:0]        key_code_i,
  input  logic              irq_clear_i,
  output soc_pkg::bus_rsp_t cpu_rsp_o,
  output logic              irq_o
);
  import soc_pkg::*;

  // DMA master side
  bus_req_t dma_mreq;
  bus_rsp_t dma_mrsp;
  // Slave sides
  bus_req_t mem_req;
  bus_rsp_t mem_rsp;
  bus_req_t dreg_req;
  bus_rsp_t dreg_rsp;
  bus_req_t key_req;
  bus_rsp_t key_rsp;

  ////////////////////////////////////////////////////////////
  // Bus
  ////////////////////////////////////////////////////////////

  bus_interconnect u_bus_interconnect (
    .clk        (clk),
    .reset_i    (reset_i),
    .cpu_req_i  (cpu_req_i),
    .dma_req_i  (dma_mreq),
    .mem_rsp_i  (mem_rsp),
    .dreg_rsp_i (dreg_rsp),
    .key_rsp_i  (key_rsp),
    .cpu_rsp_o  (cpu_rsp_o),
    .dma_rsp_o  (dma_mrsp),
    .mem_req_o  (mem_req),
    .dreg_req_o (dreg_req),
    .key_req_o  (key_req)
  );

  ////////////////////////////////////////////////////////////
  // Slaves and DMA
  ////////////////////////////////////////////////////////////

  main_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_main_mem (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (mem_req),
    .rsp_o   (mem_rsp)
  );

  keyboard #(
    .KEY_DEPTH (KEY_DEPTH)
  ) u_keyboard (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_i       (key_req),
    .key_valid_i (key_valid_i),
    .key_code_i  (key_code_i),
    .rsp_o       (key_rsp)
  );

  // Register slave and copy master in one block
  dma_engine u_dma_engine (
    .clk         (clk),
    .reset_i     (reset_i),
    .s_req_i     (dreg_req),
    .m_rsp_i     (dma_mrsp),
    .irq_clear_i (irq_clear_i),
    .s_rsp_o     (dreg_rsp),
    .m_req_o     (dma_mreq),
    .irq_o       (irq_o)
  );

endmodule

`default_nettype wire

// ==== sim/soc_checker.sv ====
// Testbench checker, watches the CPU port, keyboard input and interrupt
// Shadow memory, shadow FIFO and shadow DMA registers follow observed traffic
// Keyboard strobes must not coincide with a keyboard read access
// The copy is applied to the shadow memory when irq_o rises
// Memory reads of bytes never written expect X
`timescale 1ns/1ps
`default_nettype none

module soc_checker #(
  parameter int MEM_WORDS = 1024,
  parameter int KEY_DEPTH = 8
) (
  input  logic              clk,
  input  logic              reset_i,
  input  soc_pkg::bus_req_t cpu_req_i,
  input  soc_pkg::bus_rsp_t cpu_rsp_i,
  input  logic              key_valid_i,
  input  logic [7:0]        key_code_i,
  input  logic              irq_i,
  input  logic              irq_clear_i,
  output int                err_cnt_o,
  output int                chk_cnt_o
);
  import soc_pkg::*;

  logic [31:0] shmem [int];
  logic [7:0]  shfifo [$];
  logic        sh_ovf;
  logic [31:0] sh_src;
  logic [31:0] sh_dst;
  logic [31:0] sh_len;
  // Copy started, irq_o not yet seen
  logic        pending;
  logic        irq_d;
  logic        clr_d;
  logic        cyc_d;
  logic        contended;
  // Busy and done as the DMA slave saw them one cycle back
  logic [1:0]  ctrl_d;
  int          lat;

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic flag_mismatch(input logic [31:0] addr, input logic [31:0] exp,
                               input logic [31:0] got);
    $display("[FAIL] %0t ns: read of 0x%08h expected 0x%08h got 0x%08h",
             $time, addr, exp, got);
    err_cnt_o++;
  endtask

  task automatic flag_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_cnt_o++;
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Expected read data from the address and the shadows
  function automatic logic [31:0] ref_rdata(input logic [31:0] addr,
                                            input logic [1:0]  status);
    int idx;
    idx = int'(addr[31:2] % MEM_WORDS);
    case (addr[31:28])
      4'h0: begin
        if (shmem.exists(idx)) begin
          return shmem[idx];
        end
        return 'x;
      end
      4'h1: begin
        case (addr[3:0])
          DMA_SRC_OFS:  return sh_src;
          DMA_DST_OFS:  return sh_dst;
          DMA_LEN_OFS:  return sh_len;
          DMA_CTRL_OFS: return {30'b0, status};
          default:      return 32'h0;
        endcase
      end
      4'h2: begin
        if (addr[3:0] == KEY_DATA_OFS) begin
          if (shfifo.size() == 0) begin
            return 32'h0;
          end
          return {23'b0, 1'b1, shfifo[0]};
        end
        if (addr[3:0] == KEY_STAT_OFS) begin
          return {23'b0, sh_ovf, 8'(shfifo.size())};
        end
        return 32'h0;
      end
      // Unmapped
      default: return 32'h0;
    endcase
  endfunction

  // Pop on data read, clear overflow on status read
  task automatic read_effects(input logic [31:0] addr);
    if (addr[31:28] == 4'h2) begin
      if (addr[3:0] == KEY_DATA_OFS && shfifo.size() != 0) begin
        void'(shfifo.pop_front());
      end
      if (addr[3:0] == KEY_STAT_OFS) begin
        sh_ovf = 1'b0;
      end
    end
  endtask

  // Memory bytes under strobe, DMA registers while idle
  task automatic write_effects(input bus_req_t req, output logic zero_start);
    int          idx;
    logic [31:0] w;
    zero_start = 1'b0;
    case (req.addr[31:28])
      4'h0: begin
        idx = int'(req.addr[31:2] % MEM_WORDS);
        w   = shmem.exists(idx) ? shmem[idx] : 'x;
        for (int b = 0; b < 4; b++) begin
          if (req.strb[b]) begin
            w[8*b +: 8] = req.wdata[8*b +: 8];
          end
        end
        shmem[idx] = w;
      end
      4'h1: begin
        if (!pending) begin
          case (req.addr[3:0])
            DMA_SRC_OFS: sh_src = req.wdata;
            DMA_DST_OFS: sh_dst = req.wdata;
            DMA_LEN_OFS: sh_len = req.wdata;
            DMA_CTRL_OFS: begin
              if (req.wdata[0] && sh_len == 0) begin
                zero_start = 1'b1;
              end else if (req.wdata[0]) begin
                pending = 1'b1;
              end
            end
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  endtask

  // Word by word, same order as the engine
  task automatic apply_copy();
    int s;
    int d;
    for (int i = 0; i < int'(sh_len); i++) begin
      s = int'((sh_src[31:2] + 32'(i)) % MEM_WORDS);
      d = int'((sh_dst[31:2] + 32'(i)) % MEM_WORDS);
      shmem[d] = shmem.exists(s) ? shmem[s] : 'x;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] exp;
    logic        zero_start;
    zero_start = 1'b0;
    if (reset_i) begin
      shfifo.delete();
      sh_ovf    = 1'b0;
      sh_src    = '0;
      sh_dst    = '0;
      sh_len    = '0;
      pending   = 1'b0;
      irq_d     = 1'b0;
      clr_d     = 1'b0;
      cyc_d     = 1'b0;
      contended = 1'b0;
      ctrl_d    = '0;
      lat       = 0;
      err_cnt_o = 0;
      chk_cnt_o = 0;
    end else begin
      // Cycles since cyc rose, DMA activity excuses a late ack
      if (cpu_req_i.cyc && !cyc_d) begin
        lat       = 0;
        contended = pending;
      end else if (cpu_req_i.cyc) begin
        lat++;
        contended = contended | pending;
      end
      if (cpu_rsp_i.ack) begin
        chk_cnt_o++;
        if (!contended && lat != 2) begin
          flag_error($sformatf("ack for 0x%08h came %0d cycles after cyc, not 2",
                               cpu_req_i.addr, lat));
        end
        if (cpu_req_i.we) begin
          write_effects(cpu_req_i, zero_start);
        end else begin
          exp = ref_rdata(cpu_req_i.addr, ctrl_d);
          if (cpu_rsp_i.rdata !== exp) begin
            flag_mismatch(cpu_req_i.addr, exp, cpu_rsp_i.rdata);
          end
          read_effects(cpu_req_i.addr);
        end
      end
      ctrl_d = {irq_i, pending & ~irq_i};

      // Interrupt
      if (zero_start && !irq_i) begin
        flag_error("zero-length copy did not raise irq_o");
      end
      if (irq_i && !irq_d && !pending && !zero_start) begin
        flag_error("irq_o rose with no copy running");
      end
      if (clr_d && irq_i && !pending && !zero_start) begin
        flag_error("irq_o still high after irq_clear_i");
      end
      if (pending && irq_i) begin
        apply_copy();
        pending = 1'b0;
      end

      // Strobe lands after any read of this cycle
      if (key_valid_i) begin
        if (shfifo.size() == KEY_DEPTH) begin
          sh_ovf = 1'b1;
        end else begin
          shfifo.push_back(key_code_i);
        end
      end
      irq_d = irq_i;
      clr_d = irq_clear_i;
      cyc_d = cpu_req_i.cyc;
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_soc.sv ====
// SoC testbench driving the CPU port as the bus master
// All tasks start and end on a rising edge
// Reads of bytes never written return X on both sides
// Watchdog bound from the planned access count and the DMA copy lengths
`timescale 1ns/1ps
`default_nettype none

module tb_soc;
  import soc_pkg::*;

  localparam int MEM_WORDS   = 1024;
  localparam int KEY_DEPTH   = 8;
  localparam int MAX_LEN     = 32;
  localparam int N_ACCESS    = 400;
  // Two nonzero copies at most MAX_LEN words each
  localparam int TIMEOUT_CYC = 10 + N_ACCESS * 40 + 2 * 4 * MAX_LEN * 10;

  localparam logic [31:0] DMA_BASE = 32'h1000_0000;
  localparam logic [31:0] KEY_BASE = 32'h2000_0000;
  localparam logic [31:0] SRC_A    = 32'h0000_0400;
  localparam logic [31:0] DST_A    = 32'h0000_0800;
  localparam logic [31:0] SRC_B    = 32'h0000_0C00;
  localparam logic [31:0] DST_B    = 32'h0000_0E00;
  localparam logic [31:0] CPU_B    = 32'h0000_0100;

  logic        clk;
  logic        reset;
  bus_req_t    cpu_req;
  bus_rsp_t    cpu_rsp;
  logic        key_valid;
  logic [7:0]  key_code;
  logic        irq_clear;
  logic        irq;
  logic [31:0] rng_q;
  int          err_cnt;
  int          chk_cnt;
  int          err_base;
  int          tests_run;
  int          tests_failed;

  soc_system #(
    .MEM_WORDS (MEM_WORDS),
    .KEY_DEPTH (KEY_DEPTH)
  ) dut (
    .clk         (clk),
    .reset_i     (reset),
    .cpu_req_i   (cpu_req),
    .key_valid_i (key_valid),
    .key_code_i  (key_code),
    .irq_clear_i (irq_clear),
    .cpu_rsp_o   (cpu_rsp),
    .irq_o       (irq)
  );

  soc_checker #(
    .MEM_WORDS (MEM_WORDS),
    .KEY_DEPTH (KEY_DEPTH)
  ) chk (
    .clk         (clk),
    .reset_i     (reset),
    .cpu_req_i   (cpu_req),
    .cpu_rsp_i   (cpu_rsp),
    .key_valid_i (key_valid),
    .key_code_i  (key_code),
    .irq_i       (irq),
    .irq_clear_i (irq_clear),
    .err_cnt_o   (err_cnt),
    .chk_cnt_o   (chk_cnt)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand32();
    rng_q = rng_q ^ (rng_q << 13);
    rng_q = rng_q ^ (rng_q >> 17);
    rng_q = rng_q ^ (rng_q << 5);
    return rng_q;
  endfunction

  // Hold the request until ack and then idle one cycle
  task automatic bus_access(input logic we, input logic [3:0] strb, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    cpu_req <= '{cyc: 1'b1, we: we, strb: strb, addr: addr, wdata: wdata};
    @(posedge clk);
    while (!cpu_rsp.ack) begin
      @(posedge clk);
    end
    rdata = cpu_rsp.rdata;
    cpu_req <= '0;
    @(posedge clk);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, strb, addr, data, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(1'b0, 4'h0, addr, 32'h0, data);
  endtask

  // Back-to-back scan codes
  task automatic key_strobes(input int n);
    for (int i = 0; i < n; i++) begin
      key_valid <= 1'b1;
      key_code  <= 8'(rand32() >> 24);
      @(posedge clk);
    end
    key_valid <= 1'b0;
    @(posedge clk);
  endtask

  // One-cycle interrupt clear pulse
  task automatic clear_irq();
    irq_clear <= 1'b1;
    @(posedge clk);
    irq_clear <= 1'b0;
    @(posedge clk);
  endtask

  task automatic start_copy(input logic [31:0] src, input logic [31:0] dst,
                            input logic [31:0] len);
    bus_write(DMA_BASE | 32'(DMA_SRC_OFS), 4'hF, src);
    bus_write(DMA_BASE | 32'(DMA_DST_OFS), 4'hF, dst);
    bus_write(DMA_BASE | 32'(DMA_LEN_OFS), 4'hF, len);
    bus_write(DMA_BASE | 32'(DMA_CTRL_OFS), 4'hF, 32'h1);
  endtask

  // Poll CTRL until the done bit
  task automatic wait_done();
    logic [31:0] rd;
    do begin
      bus_read(DMA_BASE | 32'(DMA_CTRL_OFS), rd);
    end while (!rd[1]);
  endtask

  // Counts are stable at the falling edge
  task automatic finish_test(input string name);
    @(negedge clk);
    tests_run++;
    if (err_cnt == err_base) begin
      $display("Test %0d %s: PASS", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL, %0d errors", tests_run, name, err_cnt - err_base);
    end
    err_base = err_cnt;
    @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_memory();
    logic [31:0] r;
    logic [31:0] rd;
    for (int i = 0; i < 32; i++) begin
      bus_write(32'(i * 4), 4'hF, rand32());
    end
    // Random bytes over the same 32 words
    for (int i = 0; i < 40; i++) begin
      r = rand32();
      bus_write({25'b0, r[4:0], 2'b00}, r[11:8], rand32());
    end
    for (int i = 0; i < 32; i++) begin
      bus_read(32'(i * 4), rd);
    end
    finish_test("memory byte strobes");
  endtask

  task automatic test_keyboard();
    logic [31:0] rd;
    bus_read(KEY_BASE, rd);
    key_strobes(3);
    repeat (4) bus_read(KEY_BASE, rd);
    // Overflow drops the last code
    key_strobes(KEY_DEPTH + 1);
    bus_write(KEY_BASE, 4'hF, 32'h1AB);
    bus_read(KEY_BASE | 32'(KEY_STAT_OFS), rd);
    bus_read(KEY_BASE | 32'(KEY_STAT_OFS), rd);
    repeat (KEY_DEPTH + 1) bus_read(KEY_BASE, rd);
    finish_test("keyboard FIFO and overflow");
  endtask

  task automatic test_dma_copy();
    logic [31:0] len;
    logic [31:0] rd;
    len = 1 + rand32() % (MAX_LEN - 1);
    for (int i = 0; i < int'(len); i++) begin
      bus_write(SRC_A + 32'(i * 4), 4'hF, rand32());
    end
    start_copy(SRC_A, DST_A, len);
    wait_done();
    for (int i = 0; i < int'(len); i++) begin
      bus_read(DST_A + 32'(i * 4), rd);
    end
    bus_read(DMA_BASE | 32'(DMA_LEN_OFS), rd);
    // Interrupt low so the empty copy has to raise it again
    clear_irq();
    // Empty copy over the same destination
    start_copy(CPU_B, DST_A, 32'h0);
    wait_done();
    for (int i = 0; i < int'(len); i++) begin
      bus_read(DST_A + 32'(i * 4), rd);
    end
    finish_test("DMA copy and zero length");
  endtask

  task automatic test_dma_under_load();
    logic [31:0] len;
    logic [31:0] r;
    logic [31:0] rd;
    len = 16 + rand32() % 16;
    for (int i = 0; i < int'(len); i++) begin
      bus_write(SRC_B + 32'(i * 4), 4'hF, rand32());
    end
    start_copy(SRC_B, DST_B, len);
    // CPU traffic while the engine owns part of the bus time
    for (int i = 0; i < 16; i++) begin
      r = rand32();
      bus_write(CPU_B + 32'(i * 4), 4'hF, rand32());
      // Any word already written in this loop
      bus_read(CPU_B + 32'((int'(r[3:0]) % (i + 1)) * 4), rd);
    end
    wait_done();
    for (int i = 0; i < int'(len); i++) begin
      bus_read(DST_B + 32'(i * 4), rd);
    end
    finish_test("DMA copy under CPU traffic");
  endtask

  task automatic test_irq_clear_unmapped();
    logic [31:0] rd;
    clear_irq();
    bus_read(DMA_BASE | 32'(DMA_CTRL_OFS), rd);
    bus_write(32'h3000_0000, 4'hF, rand32());
    bus_write(32'hF000_0004, 4'hF, rand32());
    bus_read(32'h3000_0000, rd);
    bus_read(32'hF000_0004, rd);
    // Aliases of the unmapped writes stay untouched
    for (int i = 0; i < 4; i++) begin
      bus_read(32'(i * 4), rd);
    end
    finish_test("irq clear and unmapped access");
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    reset        = 1'b1;
    cpu_req      = '0;
    key_valid    = 1'b0;
    key_code     = 8'h0;
    irq_clear    = 1'b0;
    rng_q        = 32'h366cbb59;
    err_base     = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    test_memory();
    test_keyboard();
    test_dma_copy();
    test_dma_under_load();
    test_irq_clear_unmapped();
    repeat (4) @(posedge clk);
    @(negedge clk);
    $display("Summary: %0d tests, %0d failed, %0d accesses checked, %0d errors",
             tests_run, tests_failed, chk_cnt, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles, an access or copy hung",
             TIMEOUT_CYC);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
common/soc_pkg.sv
rtl/bus_interconnect.sv
rtl/main_mem.sv
rtl/keyboard.sv
dma/dma_engine.sv
rtl/soc_system.sv
sim/soc_checker.sv
sim/tb_soc.sv
